// ==== hdl/streamer_pkg.sv ====
// control plane and output stream types of the load streamer
// strides are unsigned byte counts, descriptor must stay stable while a transfer runs
package streamer_pkg;

  localparam int unsigned STREAM_DW = 32; // output stream width, 4 bytes per beat

  // transfer descriptor, written by the host before start
  typedef struct packed {
    logic [31:0] base_addr;   // first byte address, any alignment
    logic [15:0] tot_len;     // total beats in the transfer
    logic [15:0] line_len;    // beats per line
    logic [15:0] beat_stride; // bytes between beats of a line
    logic [15:0] line_stride; // bytes between line starts
  } addr_cfg_t;

  // status back to the host
  typedef struct packed {
    logic ready_start; // level, high in idle
    logic done;        // one-cycle pulse at end of transfer
    logic addr_done;   // address generator has handed off everything
  } streamer_flags_t;

  // one output beat, ready comes back on its own wire
  typedef struct packed {
    logic                 valid;
    logic [STREAM_DW-1:0] data;
  } stream_beat_t;

  // transfer FSM
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0, // waiting for start
    ST_WORKING = 2'd1, // generator running
    ST_DRAIN   = 2'd2  // addresses out, waiting for last beats
  } streamer_state_e;

endpackage

// ==== hdl/mem_pkg.sv ====
// read-only memory port, request/grant plus in-order r_valid responses
// request address is 32-bit word aligned, response carries 8 bytes from there
package mem_pkg;

  localparam int unsigned MEM_DW = 64; // response word width
  localparam int unsigned ADDR_W = 32; // byte address width

  // request side, driven by the streamer
  typedef struct packed {
    logic              req;
    logic [ADDR_W-1:0] addr; // low two bits always zero
    logic              lrdy; // r_valid allowed only while high
  } mem_req_t;

  // response side, driven by the memory
  typedef struct packed {
    logic              gnt;     // request accepted this cycle
    logic              r_valid; // one pulse per accepted request, in order
    logic [MEM_DW-1:0] r_data;  // byte 0 in bits 7:0
  } mem_rsp_t;

endpackage

// ==== hdl/addr_gen_2d.sv ====
// 2d byte address walk, cfg_i must hold still until done_o and a clear
// tot_len and line_len are assumed nonzero
`timescale 1ns/1ps

module addr_gen_2d #(
  parameter int unsigned TRANS_CNT = 16
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       clear_i,
  input  logic                       enable_i,
  input  streamer_pkg::addr_cfg_t    cfg_i,
  output logic                       addr_valid_o,
  output logic [mem_pkg::ADDR_W-1:0] addr_o,
  input  logic                       addr_ready_i,
  output logic                       done_o
);

  localparam int unsigned AW = mem_pkg::ADDR_W;

  logic [TRANS_CNT-1:0] trans_cnt_q; // addresses handed off so far
  logic [15:0]          beat_cnt_q;  // beat index inside current line
  logic [AW-1:0]        beat_off_q;  // offset from line start
  logic [AW-1:0]        line_off_q;  // offset of line start from base
  logic                 done_q;
  logic                 handoff;
  logic                 line_end;
  logic                 last_trans;

  assign addr_valid_o = enable_i & ~done_q; // held until the FIFO takes it
  assign addr_o       = cfg_i.base_addr + line_off_q + beat_off_q;
  assign handoff      = addr_valid_o & addr_ready_i;
  assign line_end     = (beat_cnt_q == cfg_i.line_len - 16'd1);
  assign last_trans   = (trans_cnt_q + 1'b1 == TRANS_CNT'(cfg_i.tot_len));
  assign done_o       = done_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      trans_cnt_q <= '0;
      beat_cnt_q  <= '0;
      beat_off_q  <= '0;
      line_off_q  <= '0;
      done_q      <= 1'b0;
    end else if (clear_i) begin // back to base for next transfer
      trans_cnt_q <= '0;
      beat_cnt_q  <= '0;
      beat_off_q  <= '0;
      line_off_q  <= '0;
      done_q      <= 1'b0;
    end else if (handoff) begin
      trans_cnt_q <= trans_cnt_q + 1'b1;
      done_q      <= last_trans; // sticky, no handoff once set
      if (line_end) begin
        // wrap to start of next line
        beat_cnt_q <= '0;
        beat_off_q <= '0;
        line_off_q <= line_off_q + AW'(cfg_i.line_stride);
      end else begin
        beat_cnt_q <= beat_cnt_q + 16'd1;
        beat_off_q <= beat_off_q + AW'(cfg_i.beat_stride);
      end
    end
  end

endmodule

// ==== hdl/sync_fifo.sv ====
// flop FIFO, head on data_o while not empty, push when full and pop when empty ignored
// no fall-through, a pushed entry is visible one cycle later
`timescale 1ns/1ps

module sync_fifo #(
  parameter int unsigned WIDTH = 32,
  parameter int unsigned DEPTH = 2
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             push_i,
  input  logic [WIDTH-1:0] data_i,
  output logic             full_o,
  input  logic             pop_i,
  output logic [WIDTH-1:0] data_o,
  output logic             empty_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] cnt_q; // occupancy
  logic             do_push, do_pop;

  assign full_o  = (cnt_q == CNT_W'(DEPTH));
  assign empty_o = (cnt_q == '0);
  assign do_push = push_i & ~full_o;
  assign do_pop  = pop_i & ~empty_o;
  assign data_o  = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      if (do_push && !do_pop) cnt_q <= cnt_q + 1'b1;
      else if (do_pop && !do_push) cnt_q <= cnt_q - 1'b1;
    end
  end

  // storage, contents only matter while counted
  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

endmodule

// ==== hdl/load_streamer.sv ====
// memory read gating, response hold and byte realignment for the load stream
// clear_i expects the memory port quiet, no read outstanding
`timescale 1ns/1ps

module load_streamer #(
  parameter int unsigned TRANS_CNT = 16
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          enable_i,
  input  logic                          start_i,
  input  streamer_pkg::addr_cfg_t       cfg_i,
  input  logic                          gen_done_i,
  input  logic                          addr_empty_i,
  input  logic [mem_pkg::ADDR_W-1:0]    addr_head_i,
  input  logic [1:0]                    offset_head_i,
  input  mem_pkg::mem_rsp_t             mem_rsp_i,
  input  logic                          stream_ready_i,
  output logic                          gen_en_o,
  output logic                          gen_clr_o,
  output logic                          addr_pop_o,
  output logic                          offset_push_o,
  output logic                          offset_pop_o,
  output mem_pkg::mem_req_t             mem_req_o,
  output streamer_pkg::stream_beat_t    stream_o,
  output streamer_pkg::streamer_flags_t flags_o
);

  localparam int unsigned AW = mem_pkg::ADDR_W;

  streamer_pkg::streamer_state_e state_q, state_d;

  logic                       busy;
  logic                       xfer_end;   // last beat out, addresses all sent
  logic                       mem_accept; // req and gnt
  logic                       beat_valid;
  logic                       beat_fire;  // valid and ready
  logic                       hold_load;
  logic                       held_valid_q;
  logic [mem_pkg::MEM_DW-1:0] held_data_q;
  logic [mem_pkg::MEM_DW-1:0] word_sel;
  logic [TRANS_CNT-1:0]       beat_cnt_q;

  // transfer FSM
  always_comb begin
    state_d  = state_q;
    xfer_end = 1'b0;
    case (state_q)
      streamer_pkg::ST_IDLE: begin
        if (start_i) state_d = streamer_pkg::ST_WORKING;
      end
      streamer_pkg::ST_WORKING: begin
        if (gen_done_i) state_d = streamer_pkg::ST_DRAIN;
      end
      streamer_pkg::ST_DRAIN: begin
        // every address granted and every beat taken
        if (enable_i && addr_empty_i && beat_cnt_q == TRANS_CNT'(cfg_i.tot_len)) begin
          xfer_end = 1'b1;
          state_d  = streamer_pkg::ST_IDLE;
        end
      end
      default: state_d = streamer_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)       state_q <= streamer_pkg::ST_IDLE;
    else if (clear_i)  state_q <= streamer_pkg::ST_IDLE;
    else if (enable_i) state_q <= state_d;
  end

  assign busy      = (state_q != streamer_pkg::ST_IDLE);
  assign gen_en_o  = enable_i & busy;
  assign gen_clr_o = clear_i | xfer_end; // rewind generator for next start

  // requests only while the stream can take the answer
  assign mem_req_o.req  = enable_i & busy & ~addr_empty_i & stream_ready_i;
  assign mem_req_o.addr = mem_req_o.req ? {addr_head_i[AW-1:2], 2'b00} : '0;
  assign mem_req_o.lrdy = stream_ready_i;
  assign mem_accept     = mem_req_o.req & mem_rsp_i.gnt;
  assign addr_pop_o     = mem_accept;
  assign offset_push_o  = mem_accept; // byte offset follows its request

  // output beat, held word is older so it goes first
  assign beat_valid     = mem_rsp_i.r_valid | held_valid_q;
  assign stream_o.valid = enable_i & beat_valid;
  assign beat_fire      = stream_o.valid & stream_ready_i;
  assign offset_pop_o   = beat_fire;
  assign word_sel       = held_valid_q ? held_data_q : mem_rsp_i.r_data;
  assign stream_o.data  = word_sel[{offset_head_i, 3'b000} +: streamer_pkg::STREAM_DW];

  // capture a response that can't go out this cycle
  // not frozen by enable_i, memory keeps answering
  assign hold_load = mem_rsp_i.r_valid & (held_valid_q | ~beat_fire);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)        held_valid_q <= 1'b0;
    else if (clear_i)   held_valid_q <= 1'b0;
    else if (hold_load) held_valid_q <= 1'b1;
    else if (beat_fire) held_valid_q <= 1'b0; // held word taken
  end

  always_ff @(posedge clk_i) begin
    if (hold_load) held_data_q <= mem_rsp_i.r_data;
  end

  // beats accepted in this transfer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni)                   beat_cnt_q <= '0;
    else if (clear_i || xfer_end)  beat_cnt_q <= '0;
    else if (beat_fire)            beat_cnt_q <= beat_cnt_q + 1'b1;
  end

  assign flags_o.ready_start = ~busy;
  assign flags_o.done        = xfer_end;
  assign flags_o.addr_done   = gen_done_i;

endmodule

// ==== hdl/load_streamer_top.sv ====
// load streamer top, ADDR_MIS_DEPTH must cover the reads in flight
`timescale 1ns/1ps

module load_streamer_top #(
  parameter int unsigned TRANS_CNT      = 16,
  parameter int unsigned ADDR_MIS_DEPTH = 8
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          enable_i,
  input  logic                          start_i,
  input  streamer_pkg::addr_cfg_t       cfg_i,
  output streamer_pkg::streamer_flags_t flags_o,
  output mem_pkg::mem_req_t             mem_req_o,
  input  mem_pkg::mem_rsp_t             mem_rsp_i,
  output streamer_pkg::stream_beat_t    stream_o,
  input  logic                          stream_ready_i
);

  logic                       gen_en, gen_clr, gen_done;
  logic                       gen_valid;
  logic [mem_pkg::ADDR_W-1:0] gen_addr;
  logic                       addr_full, addr_empty, addr_pop;
  logic [mem_pkg::ADDR_W-1:0] addr_head;
  logic                       offset_push, offset_pop;
  logic [1:0]                 offset_head;

  addr_gen_2d #(
    .TRANS_CNT ( TRANS_CNT )
  ) i_addr_gen (
    .clk_i        ( clk_i      ),
    .rst_ni       ( rst_ni     ),
    .clear_i      ( gen_clr    ),
    .enable_i     ( gen_en     ),
    .cfg_i        ( cfg_i      ),
    .addr_valid_o ( gen_valid  ),
    .addr_o       ( gen_addr   ),
    .addr_ready_i ( ~addr_full ),
    .done_o       ( gen_done   )
  );

  // byte addresses waiting for a grant
  sync_fifo #(
    .WIDTH ( mem_pkg::ADDR_W ),
    .DEPTH ( 2               )
  ) i_addr_fifo (
    .clk_i   ( clk_i      ),
    .rst_ni  ( rst_ni     ),
    .clear_i ( clear_i    ),
    .push_i  ( gen_valid  ),
    .data_i  ( gen_addr   ),
    .full_o  ( addr_full  ),
    .pop_i   ( addr_pop   ),
    .data_o  ( addr_head  ),
    .empty_o ( addr_empty )
  );

  // byte offsets of granted reads, flags unused since depth covers all in flight
  sync_fifo #(
    .WIDTH ( 2              ),
    .DEPTH ( ADDR_MIS_DEPTH )
  ) i_offset_fifo (
    .clk_i   ( clk_i          ),
    .rst_ni  ( rst_ni         ),
    .clear_i ( clear_i        ),
    .push_i  ( offset_push    ),
    .data_i  ( addr_head[1:0] ),
    .full_o  (                ),
    .pop_i   ( offset_pop     ),
    .data_o  ( offset_head    ),
    .empty_o (                )
  );

  load_streamer #(
    .TRANS_CNT ( TRANS_CNT )
  ) i_streamer (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .enable_i       ( enable_i       ),
    .start_i        ( start_i        ),
    .cfg_i          ( cfg_i          ),
    .gen_done_i     ( gen_done       ),
    .addr_empty_i   ( addr_empty     ),
    .addr_head_i    ( addr_head      ),
    .offset_head_i  ( offset_head    ),
    .mem_rsp_i      ( mem_rsp_i      ),
    .stream_ready_i ( stream_ready_i ),
    .gen_en_o       ( gen_en         ),
    .gen_clr_o      ( gen_clr        ),
    .addr_pop_o     ( addr_pop       ),
    .offset_push_o  ( offset_push    ),
    .offset_pop_o   ( offset_pop     ),
    .mem_req_o      ( mem_req_o      ),
    .stream_o       ( stream_o       ),
    .flags_o        ( flags_o        )
  );

endmodule

// ==== bench/tb_mem_model.sv ====
// memory model, random grant and in-order latency 1 to 3 cycles, r_valid held back while lrdy low
// byte at address a reads as a[7:0] ^ 8'h5a, no reset, outputs settle 1 ns after the clock edge
`timescale 1ns/1ps

module tb_mem_model #(
  parameter int unsigned SEED = 32'hbaf0_1395
) (
  input  logic              clk_i,
  input  logic              gnt_off_i, // holds grant low
  input  mem_pkg::mem_req_t mem_req_i,
  output mem_pkg::mem_rsp_t mem_rsp_o,
  output int unsigned       pending_o  // responses not yet taken
);

  integer                     seed;
  int unsigned                cycle, rnd;
  logic [mem_pkg::MEM_DW-1:0] data_q [$]; // in-order response words
  int unsigned                due_q [$];  // first cycle each word may go out
  logic                       gnt_q, head_ready_q, take, accept;
  logic [mem_pkg::ADDR_W-1:0] acc_addr;
  logic [mem_pkg::MEM_DW-1:0] head_data_q;

  // 8 bytes starting at the word-aligned request address
  function automatic logic [mem_pkg::MEM_DW-1:0] read_word(input logic [31:0] addr);
    logic [mem_pkg::MEM_DW-1:0] w;
    logic [31:0]                a;
    for (int b = 0; b < 8; b++) begin
      a            = addr + 32'(b);
      w[8*b +: 8]  = a[7:0] ^ 8'h5a;
    end
    return w;
  endfunction

  assign mem_rsp_o = {gnt_q & ~gnt_off_i, head_ready_q & mem_req_i.lrdy, head_data_q};

  initial begin
    seed = SEED; cycle = 0; pending_o = 0;
    gnt_q = 1'b0; head_ready_q = 1'b0; head_data_q = '0;
    forever begin
      @(negedge clk_i); // sample where everything is stable
      take     = mem_rsp_o.r_valid; // lrdy high, beat leaves this cycle
      accept   = mem_req_i.req & mem_rsp_o.gnt;
      acc_addr = mem_req_i.addr;
      @(posedge clk_i);
      #1;
      cycle++;
      if (take) begin
        void'(data_q.pop_front());
        void'(due_q.pop_front());
      end
      if (accept) begin
        rnd = $random(seed);
        data_q.push_back(read_word(acc_addr));
        due_q.push_back(cycle + rnd % 3); // accepted last cycle, latency 1..3
      end
      head_ready_q = (data_q.size() > 0) && (due_q[0] <= cycle);
      head_data_q  = head_ready_q ? data_q[0] : '0;
      rnd          = $random(seed);
      gnt_q        = (rnd % 4) != 0; // grant about 3 cycles in 4
      pending_o    = data_q.size();
    end
  end

endmodule

// ==== bench/tb_load_streamer_top.sv ====
// descriptor table applied in a loop against the memory model, checks sampled at negedge
// enable_i stays high and clear_i only rises once the memory port is quiet
`timescale 1ns/1ps

module tb_load_streamer_top;

  localparam int unsigned NUM_ROWS = 8;

  typedef struct packed {
    streamer_pkg::addr_cfg_t cfg;
    logic [7:0]              bp_pct;   // percent of cycles with ready low
    logic [15:0]             abort_at; // clear after this many beats or 0 to run to done
  } row_t;

  logic                          clk_i = 1'b0;
  logic                          rst_ni, clear_i, enable_i, start_i, stream_ready_i;
  streamer_pkg::addr_cfg_t       cfg_i;
  streamer_pkg::streamer_flags_t flags_o;
  mem_pkg::mem_req_t             mem_req_o;
  mem_pkg::mem_rsp_t             mem_rsp_i;
  streamer_pkg::stream_beat_t    stream_o;
  logic                          gnt_off, busy_exp, table_ready;
  int unsigned                   pending, beat_cnt, done_cnt, bp_pct, rnd;
  int unsigned                   beat_errs, flag_errs, cnt_errs, other_errs;
  integer                        seed;
  row_t                          rows [NUM_ROWS];
  streamer_pkg::addr_cfg_t       cur_cfg; // descriptor the checker follows

  load_streamer_top #(
    .TRANS_CNT      ( 16 ),
    .ADDR_MIS_DEPTH ( 8  )
  ) load_streamer_top_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .clear_i        ( clear_i        ),
    .enable_i       ( enable_i       ),
    .start_i        ( start_i        ),
    .cfg_i          ( cfg_i          ),
    .flags_o        ( flags_o        ),
    .mem_req_o      ( mem_req_o      ),
    .mem_rsp_i      ( mem_rsp_i      ),
    .stream_o       ( stream_o       ),
    .stream_ready_i ( stream_ready_i )
  );

  tb_mem_model #(
    .SEED ( 32'hbaf0_1395 )
  ) mem_model_i (
    .clk_i     ( clk_i     ),
    .gnt_off_i ( gnt_off   ),
    .mem_req_i ( mem_req_o ),
    .mem_rsp_o ( mem_rsp_i ),
    .pending_o ( pending   )
  );

  function automatic row_t make_row(input logic [31:0] base, input logic [15:0] tot,
                                    input logic [15:0] line, input logic [15:0] bstr,
                                    input logic [15:0] lstr, input logic [7:0] bp,
                                    input logic [15:0] abort);
    row_t row;
    row.cfg    = {base, tot, line, bstr, lstr};
    row.bp_pct = bp;
    row.abort_at = abort;
    return row;
  endfunction

  function automatic logic [7:0] pattern_byte(input logic [31:0] a);
    return a[7:0] ^ 8'h5a;
  endfunction

  // four bytes upward from the byte address of beat idx in the 2d walk
  function automatic logic [31:0] exp_beat(input streamer_pkg::addr_cfg_t cfg,
                                           input int unsigned idx);
    logic [31:0] addr;
    logic [31:0] data;
    addr = cfg.base_addr + (idx / cfg.line_len) * cfg.line_stride
         + (idx % cfg.line_len) * cfg.beat_stride;
    for (int b = 0; b < 4; b++) data[8*b +: 8] = pattern_byte(addr + 32'(b));
    return data;
  endfunction

  task automatic check_beat(input streamer_pkg::stream_beat_t act,
                            input streamer_pkg::stream_beat_t want, input string what);
    if (act.valid !== want.valid || (want.valid && act.data !== want.data)) begin
      beat_errs++;
      $display("Mismatch at %0t: %s beat %0d valid %b data %h, expected valid %b data %h",
               $time, what, beat_cnt, act.valid, act.data, want.valid, want.data);
    end
  endtask

  task automatic check_flags(input streamer_pkg::streamer_flags_t act,
                             input streamer_pkg::streamer_flags_t want, input logic addr_known);
    if (act.ready_start !== want.ready_start || act.done !== want.done ||
        (addr_known && act.addr_done !== want.addr_done)) begin
      flag_errs++;
      $display("Mismatch at %0t: flags ready_start %b done %b addr_done %b, expected %b %b %b",
               $time, act.ready_start, act.done, act.addr_done,
               want.ready_start, want.done, want.addr_done);
    end
  endtask

  task automatic compare_count(input string what, input int unsigned act, input int unsigned want);
    if (act != want) begin
      cnt_errs++;
      $display("Mismatch at %0t: %s %0d, expected %0d", $time, what, act, want);
    end
  endtask

  // stop partway and let in-flight reads drain with grant held low before the clear
  task automatic abort_row(input int unsigned after_beats);
    do @(posedge clk_i); while (beat_cnt < after_beats);
    #1;
    gnt_off = 1'b1;
    do @(negedge clk_i); while (pending != 0 || stream_o.valid);
    @(posedge clk_i);
    #1;
    clear_i = 1'b1;
    @(posedge clk_i);
    #1;
    clear_i  = 1'b0;
    gnt_off  = 1'b0;
    busy_exp = 1'b0;
  endtask

  task automatic print_error_counts();
    $display("errors: beat %0d flags %0d count %0d other %0d",
             beat_errs, flag_errs, cnt_errs, other_errs);
  endtask

  initial begin
    forever #4 clk_i = ~clk_i;
  end

  // back-pressure redrawn every cycle
  initial begin
    seed           = 32'hbaf0_1395;
    stream_ready_i = 1'b1;
    forever begin
      @(posedge clk_i);
      #1;
      rnd            = $random(seed);
      stream_ready_i = (rnd % 100) >= bp_pct;
    end
  end

  // stream and flag checker
  always @(negedge clk_i) begin
    logic                          exp_done;
    streamer_pkg::streamer_flags_t exp_flags;
    exp_done              = busy_exp && beat_cnt == cur_cfg.tot_len; // cycle after last beat
    exp_flags.ready_start = ~busy_exp;
    exp_flags.done        = exp_done;
    exp_flags.addr_done   = exp_done; // low in idle and unknown while busy
    check_flags(flags_o, exp_flags, exp_done || !busy_exp);
    if (!rst_ni) begin
      check_beat(stream_o, '0, "reset");
    end else if (stream_o.valid && stream_ready_i) begin
      if (!busy_exp || beat_cnt >= cur_cfg.tot_len) begin
        other_errs++;
        $display("extra beat outside a transfer at %0t", $time);
      end else begin
        check_beat(stream_o, {1'b1, exp_beat(cur_cfg, beat_cnt)}, "stream");
      end
      beat_cnt++;
    end
    // reads only while busy and the stream can take the answer
    if (mem_req_o.req && !(busy_exp && stream_ready_i)) begin
      other_errs++;
      $display("memory request raised outside a transfer or while the stream stalled at %0t",
               $time);
    end
    if (flags_o.done) done_cnt++;
    if (exp_done) busy_exp = 1'b0;
  end

  initial begin
    int unsigned limit;
    wait (table_ready);
    limit = 500; // reset and per-row overhead
    for (int r = 0; r < NUM_ROWS; r++) limit += rows[r].cfg.tot_len * 40;
    repeat (limit) @(posedge clk_i);
    $display("watchdog expired after %0d cycles, transfer stalled", limit);
    print_error_counts();
    $display("TEST FAIL");
    $finish;
  end

  initial begin
    int unsigned r;
    rst_ni     = 1'b0;
    clear_i    = 1'b0;
    enable_i   = 1'b1;
    start_i    = 1'b0;
    cfg_i      = '0;
    cur_cfg    = '0;
    gnt_off    = 1'b0;
    busy_exp   = 1'b0;
    beat_cnt   = 0;
    done_cnt   = 0;
    bp_pct     = 0;
    beat_errs  = 0;
    flag_errs  = 0;
    cnt_errs   = 0;
    other_errs = 0;
    //                 base          tot    line   bstr   lstr   bp    abort
    rows[0] = make_row(32'h0000_1000, 16'd16, 16'd16, 16'd4, 16'd0,  8'd0,  16'd0); // aligned
    rows[1] = make_row(32'h0000_2001, 16'd8,  16'd8,  16'd4, 16'd0,  8'd0,  16'd0); // offset 1
    rows[2] = make_row(32'h0000_2102, 16'd8,  16'd8,  16'd4, 16'd0,  8'd0,  16'd0); // offset 2
    rows[3] = make_row(32'h0000_2203, 16'd8,  16'd8,  16'd4, 16'd0,  8'd15, 16'd0); // offset 3
    rows[4] = make_row(32'h0000_3000, 16'd12, 16'd4,  16'd8, 16'd64, 8'd20, 16'd0); // 2d walk
    rows[5] = make_row(32'h0000_4005, 16'd20, 16'd5,  16'd4, 16'd48, 8'd50, 16'd0); // heavy bp
    rows[6] = make_row(32'h0000_5000, 16'd24, 16'd24, 16'd4, 16'd0,  8'd25, 16'd6); // cleared
    rows[7] = make_row(32'h0000_6003, 16'd10, 16'd10, 16'd4, 16'd0,  8'd10, 16'd0);
    table_ready = 1'b1;
    repeat (8) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    for (r = 0; r < NUM_ROWS; r++) begin
      @(posedge clk_i);
      #1;
      cur_cfg  = rows[r].cfg;
      bp_pct   = rows[r].bp_pct;
      beat_cnt = 0;
      done_cnt = 0;
      cfg_i    = rows[r].cfg;
      start_i  = 1'b1;
      @(posedge clk_i);
      #1;
      start_i  = 1'b0;
      busy_exp = 1'b1;
      if (rows[r].abort_at != 0) begin
        abort_row(rows[r].abort_at);
      end else begin
        do @(posedge clk_i); while (done_cnt == 0);
        @(posedge clk_i); // a second pulse would land here
        compare_count("done pulses", done_cnt, 1);
        compare_count("beats at done", beat_cnt, cur_cfg.tot_len);
      end
    end
    repeat (2) @(posedge clk_i);
    print_error_counts();
    if (beat_errs + flag_errs + cnt_errs + other_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== compile.f ====
hdl/streamer_pkg.sv
hdl/mem_pkg.sv
hdl/addr_gen_2d.sv
hdl/sync_fifo.sv
hdl/load_streamer.sv
hdl/load_streamer_top.sv
bench/tb_mem_model.sv
bench/tb_load_streamer_top.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the load streamer testbench with Verilator, run it and scan the log
set -e
set -o pipefail
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_load_streamer_top -o tb_sim
./obj_dir/tb_sim | tee sim.log

if grep -q "TEST FAIL" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
echo "simulation finished without failure"
